// ==== common/rsa_config.svh ====
`ifndef RSA_CONFIG_SVH
`define RSA_CONFIG_SVH

// operand and frame sizes.
`define RSA_BITS       256
`define RSA_IN_BYTES   32
`define RSA_OUT_BYTES  31

// serial peripheral register map.
`define AVM_RX_ADDR     5'd0
`define AVM_TX_ADDR     5'd4
`define AVM_STATUS_ADDR 5'd8
`define AVM_TX_OK_BIT   6
`define AVM_RX_OK_BIT   7

`endif

// ==== common/rsa_pkg.sv ====
`include "rsa_config.svh"

package rsa_pkg;

    // operands of one frame, in arrival order.
    typedef struct packed {
        logic [`RSA_BITS-1:0] n;
        logic [`RSA_BITS-1:0] d;
        logic [`RSA_BITS-1:0] a;
    } operands_t;

    // one avalon-mm command as driven by the master.
    typedef struct packed {
        logic [4:0]  address;
        logic        read;
        logic        write;
        logic [31:0] writedata;
    } avm_cmd_t;

    typedef enum logic [2:0] {
        ms_poll_rx,
        ms_read_rx,
        ms_poll_tx,
        ms_write_tx,
        ms_idle
    } master_state_e;

    typedef enum logic [1:0] {
        cs_idle,
        cs_prescale,
        cs_multiply,
        cs_finish
    } core_state_e;

endpackage

// ==== source/avm_master.sv ====
`timescale 1ns/1ps
`include "rsa_config.svh"

module avm_master (
    input  logic              avm_clk,
    input  logic              avm_rst,
    input  logic [31:0]       readdata,
    input  logic              waitrequest,
    output rsa_pkg::avm_cmd_t cmd,
    input  logic              byte_want,
    output logic              byte_valid,
    output logic [7:0]        byte_data,
    input  logic              send_want,
    input  logic [7:0]        send_byte,
    output logic              send_done
);

    rsa_pkg::master_state_e state;
    logic                   xfer_ok;

    // transfer completes on an edge with waitrequest low.
    assign xfer_ok = !waitrequest;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state      <= rsa_pkg::ms_idle;
            cmd        <= '0;
            byte_valid <= 1'b0;
            send_done  <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            send_done  <= 1'b0;
            case (state)
                rsa_pkg::ms_idle: begin
                    // requesters update their level one cycle after our pulse.
                    if (send_want && !send_done) begin
                        state       <= rsa_pkg::ms_poll_tx;
                        cmd.read    <= 1'b1;
                        cmd.address <= `AVM_STATUS_ADDR;
                    end else if (byte_want && !byte_valid) begin
                        state       <= rsa_pkg::ms_poll_rx;
                        cmd.read    <= 1'b1;
                        cmd.address <= `AVM_STATUS_ADDR;
                    end
                end
                rsa_pkg::ms_poll_rx: begin
                    if (xfer_ok) begin
                        if (readdata[`AVM_RX_OK_BIT]) begin
                            state       <= rsa_pkg::ms_read_rx;
                            cmd.address <= `AVM_RX_ADDR;
                        end else begin
                            state    <= rsa_pkg::ms_idle;
                            cmd.read <= 1'b0;
                        end
                    end
                end
                rsa_pkg::ms_read_rx: begin
                    if (xfer_ok) begin
                        state      <= rsa_pkg::ms_idle;
                        cmd.read   <= 1'b0;
                        byte_valid <= 1'b1;
                    end
                end
                rsa_pkg::ms_poll_tx: begin
                    if (xfer_ok) begin
                        if (readdata[`AVM_TX_OK_BIT]) begin
                            state         <= rsa_pkg::ms_write_tx;
                            cmd.read      <= 1'b0;
                            cmd.write     <= 1'b1;
                            cmd.address   <= `AVM_TX_ADDR;
                            cmd.writedata <= {24'd0, send_byte};
                        end else begin
                            state    <= rsa_pkg::ms_idle;
                            cmd.read <= 1'b0;
                        end
                    end
                end
                rsa_pkg::ms_write_tx: begin
                    if (xfer_ok) begin
                        state     <= rsa_pkg::ms_idle;
                        cmd.write <= 1'b0;
                        send_done <= 1'b1;
                    end
                end
                default: begin
                    state <= rsa_pkg::ms_idle;
                    cmd   <= '0;
                end
            endcase
        end
    end

    // received byte, taken on the completing edge.
    always_ff @(posedge avm_clk) begin
        if (state == rsa_pkg::ms_read_rx && xfer_ok) begin
            byte_data <= readdata[7:0];
        end
    end

endmodule

// ==== source/frame_loader.sv ====
`timescale 1ns/1ps
`include "rsa_config.svh"

module frame_loader (
    input  logic               avm_clk,
    input  logic               avm_rst,
    input  logic               byte_valid,
    input  logic [7:0]         byte_data,
    input  logic               frame_sent,
    output logic               byte_want,
    output logic               start,
    output rsa_pkg::operands_t operands
);

    logic [6:0] byte_cnt;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            byte_cnt  <= 7'd0;
            byte_want <= 1'b1;
            start     <= 1'b0;
        end else begin
            start <= 1'b0;
            if (byte_valid) begin
                if (byte_cnt == 7'(3 * `RSA_IN_BYTES - 1)) begin
                    byte_cnt  <= 7'd0;
                    byte_want <= 1'b0;
                    start     <= 1'b1;
                end else begin
                    byte_cnt <= byte_cnt + 7'd1;
                end
            end
            if (frame_sent) begin
                byte_want <= 1'b1;
            end
        end
    end

    // msb first, each byte enters from the right.
    always_ff @(posedge avm_clk) begin
        if (byte_valid) begin
            if (byte_cnt < 7'(`RSA_IN_BYTES)) begin
                operands.n <= {operands.n[`RSA_BITS-9:0], byte_data};
            end else if (byte_cnt < 7'(2 * `RSA_IN_BYTES)) begin
                operands.d <= {operands.d[`RSA_BITS-9:0], byte_data};
            end else begin
                operands.a <= {operands.a[`RSA_BITS-9:0], byte_data};
            end
        end
    end

endmodule

// ==== source/frame_sender.sv ====
`timescale 1ns/1ps
`include "rsa_config.svh"

module frame_sender (
    input  logic                 avm_clk,
    input  logic                 avm_rst,
    input  logic                 finished,
    input  logic [`RSA_BITS-1:0] result,
    input  logic                 send_done,
    output logic                 send_want,
    output logic [7:0]           send_byte,
    output logic                 frame_sent
);

    // only the low bytes that go out are kept.
    logic [8*`RSA_OUT_BYTES-1:0] out_sh;
    logic [4:0]                  sent_cnt;

    assign send_byte = out_sh[8*`RSA_OUT_BYTES-1 -: 8];

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            send_want  <= 1'b0;
            sent_cnt   <= 5'd0;
            frame_sent <= 1'b0;
        end else begin
            frame_sent <= 1'b0;
            if (finished) begin
                send_want <= 1'b1;
                sent_cnt  <= 5'd0;
            end else if (send_done) begin
                if (sent_cnt == 5'(`RSA_OUT_BYTES - 1)) begin
                    send_want  <= 1'b0;
                    frame_sent <= 1'b1;
                    sent_cnt   <= 5'd0;
                end else begin
                    sent_cnt <= sent_cnt + 5'd1;
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (finished) begin
            out_sh <= result[8*`RSA_OUT_BYTES-1:0];
        end else if (send_done) begin
            out_sh <= out_sh << 8;
        end
    end

endmodule

// ==== rsa_core/mont_mult.sv ====
`timescale 1ns/1ps
`include "rsa_config.svh"

module mont_mult (
    input  logic                 avm_clk,
    input  logic                 avm_rst,
    input  logic                 start,
    input  logic [`RSA_BITS-1:0] x,
    input  logic [`RSA_BITS-1:0] y,
    input  logic [`RSA_BITS-1:0] n,
    output logic                 done,
    output logic [`RSA_BITS-1:0] product
);

    logic [`RSA_BITS-1:0] x_sh;
    logic [`RSA_BITS:0]   acc;
    logic [`RSA_BITS+1:0] sum_y;
    logic [`RSA_BITS+1:0] sum_n;
    logic [`RSA_BITS:0]   diff;
    logic [8:0]           cnt;
    logic                 busy;
    logic                 fin;

    // acc stays below 2n, so two guard bits cover the sum.
    assign sum_y = {1'b0, acc} + (x_sh[0] ? {2'b00, y} : '0);
    assign sum_n = sum_y[0] ? sum_y + {2'b00, n} : sum_y;
    assign diff  = acc - {1'b0, n};

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy <= 1'b0;
            fin  <= 1'b0;
            cnt  <= 9'd0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= 9'd0;
            end else if (busy) begin
                cnt <= cnt + 9'd1;
                if (cnt == 9'(`RSA_BITS - 1)) begin
                    busy <= 1'b0;
                    fin  <= 1'b1;
                end
            end else if (fin) begin
                fin  <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) begin
            acc  <= '0;
            x_sh <= x;
        end else if (busy) begin
            acc  <= sum_n[`RSA_BITS+1:1];
            x_sh <= x_sh >> 1;
        end else if (fin) begin
            // single conditional subtract.
            product <= diff[`RSA_BITS] ? acc[`RSA_BITS-1:0] : diff[`RSA_BITS-1:0];
        end
    end

endmodule

// ==== rsa_core/rsa_core.sv ====
`timescale 1ns/1ps
`include "rsa_config.svh"

module rsa_core (
    input  logic                 avm_clk,
    input  logic                 avm_rst,
    input  logic                 start,
    input  rsa_pkg::operands_t   operands,
    output logic                 finished,
    output logic [`RSA_BITS-1:0] result
);

    rsa_pkg::core_state_e state;
    logic [8:0]           cnt;
    logic                 mm_start;
    logic                 mul_done;
    logic                 sq_done;
    logic [`RSA_BITS-1:0] base;
    logic [`RSA_BITS-1:0] acc;
    logic [`RSA_BITS-1:0] d_sh;
    logic [`RSA_BITS-1:0] mul_y;
    logic [`RSA_BITS-1:0] mul_p;
    logic [`RSA_BITS-1:0] sq_p;

    // 2t mod n, valid for t below n.
    function automatic logic [`RSA_BITS-1:0] mod_dbl(input logic [`RSA_BITS-1:0] t,
                                                     input logic [`RSA_BITS-1:0] m);
        logic [`RSA_BITS:0] t2;
        logic [`RSA_BITS:0] diff;
        t2   = {t, 1'b0};
        diff = t2 - {1'b0, m};
        return diff[`RSA_BITS] ? t2[`RSA_BITS-1:0] : diff[`RSA_BITS-1:0];
    endfunction

    // multiply by one to leave the montgomery domain.
    assign mul_y = (state == rsa_pkg::cs_finish) ? `RSA_BITS'(1) : base;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state    <= rsa_pkg::cs_idle;
            cnt      <= 9'd0;
            mm_start <= 1'b0;
            finished <= 1'b0;
        end else begin
            mm_start <= 1'b0;
            finished <= 1'b0;
            case (state)
                rsa_pkg::cs_idle: begin
                    if (start) begin
                        state <= rsa_pkg::cs_prescale;
                        cnt   <= 9'd0;
                    end
                end
                rsa_pkg::cs_prescale: begin
                    cnt <= cnt + 9'd1;
                    if (cnt == 9'(`RSA_BITS - 1)) begin
                        state    <= rsa_pkg::cs_multiply;
                        cnt      <= 9'd0;
                        mm_start <= 1'b1;
                    end
                end
                rsa_pkg::cs_multiply: begin
                    if (mul_done && sq_done) begin
                        cnt      <= cnt + 9'd1;
                        mm_start <= 1'b1;
                        if (cnt == 9'(`RSA_BITS - 1)) begin
                            state <= rsa_pkg::cs_finish;
                        end
                    end
                end
                rsa_pkg::cs_finish: begin
                    if (mul_done && sq_done) begin
                        state    <= rsa_pkg::cs_idle;
                        finished <= 1'b1;
                    end
                end
                default: state <= rsa_pkg::cs_idle;
            endcase
        end
    end

    // base and accumulator are both scaled by 2^256 mod n.
    always_ff @(posedge avm_clk) begin
        if (state == rsa_pkg::cs_idle && start) begin
            base <= operands.a;
            acc  <= `RSA_BITS'(1);
            d_sh <= operands.d;
        end else if (state == rsa_pkg::cs_prescale) begin
            base <= mod_dbl(base, operands.n);
            acc  <= mod_dbl(acc, operands.n);
        end else if (state == rsa_pkg::cs_multiply && mul_done) begin
            if (d_sh[0]) begin
                acc <= mul_p;
            end
            base <= sq_p;
            d_sh <= d_sh >> 1;
        end
        if (state == rsa_pkg::cs_finish && mul_done) begin
            result <= mul_p;
        end
    end

    mont_mult i_mul (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mm_start),
        .x       (acc),
        .y       (mul_y),
        .n       (operands.n),
        .done    (mul_done),
        .product (mul_p)
    );

    mont_mult i_sq (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mm_start),
        .x       (base),
        .y       (base),
        .n       (operands.n),
        .done    (sq_done),
        .product (sq_p)
    );

endmodule

// ==== source/rsa_wrapper.sv ====
`timescale 1ns/1ps
`include "rsa_config.svh"

module rsa_wrapper (
    input  logic        avm_clk,
    input  logic        avm_rst,
    output logic [4:0]  avm_address,
    output logic        avm_read,
    input  logic [31:0] avm_readdata,
    output logic        avm_write,
    output logic [31:0] avm_writedata,
    input  logic        avm_waitrequest
);

    rsa_pkg::avm_cmd_t    cmd;
    rsa_pkg::operands_t   operands;
    logic                 byte_want;
    logic                 byte_valid;
    logic [7:0]           byte_data;
    logic                 send_want;
    logic [7:0]           send_byte;
    logic                 send_done;
    logic                 frame_sent;
    logic                 start;
    logic                 finished;
    logic [`RSA_BITS-1:0] result;

    assign avm_address   = cmd.address;
    assign avm_read      = cmd.read;
    assign avm_write     = cmd.write;
    assign avm_writedata = cmd.writedata;

    avm_master i_master (
        .avm_clk     (avm_clk),
        .avm_rst     (avm_rst),
        .readdata    (avm_readdata),
        .waitrequest (avm_waitrequest),
        .cmd         (cmd),
        .byte_want   (byte_want),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .send_want   (send_want),
        .send_byte   (send_byte),
        .send_done   (send_done)
    );

    frame_loader i_loader (
        .avm_clk    (avm_clk),
        .avm_rst    (avm_rst),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .frame_sent (frame_sent),
        .byte_want  (byte_want),
        .start      (start),
        .operands   (operands)
    );

    rsa_core i_core (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (start),
        .operands (operands),
        .finished (finished),
        .result   (result)
    );

    frame_sender i_sender (
        .avm_clk    (avm_clk),
        .avm_rst    (avm_rst),
        .finished   (finished),
        .result     (result),
        .send_done  (send_done),
        .send_want  (send_want),
        .send_byte  (send_byte),
        .frame_sent (frame_sent)
    );

endmodule

// ==== bench/rsa_chk.sv ====
`timescale 1ns/1ps

module rsa_chk (
    input logic              avm_clk,
    input logic              avm_rst,
    input rsa_pkg::avm_cmd_t cmd,
    input logic              avm_waitrequest,
    input logic              start,
    input logic              finished
);

    int fail_cnt = 0;

    a_rw_exclusive: assert property (@(posedge avm_clk) disable iff (avm_rst)
        !(cmd.read && cmd.write))
        else begin
            fail_cnt++;
            $error("read and write high in the same cycle");
        end

    // command frozen while the slave stalls.
    a_cmd_stable: assert property (@(posedge avm_clk) disable iff (avm_rst)
        ($past(cmd.read || cmd.write) && $past(avm_waitrequest)) |-> (cmd == $past(cmd)))
        else begin
            fail_cnt++;
            $error("bus command changed under waitrequest");
        end

    a_start_pulse: assert property (@(posedge avm_clk) disable iff (avm_rst)
        $past(start) |-> !start)
        else begin
            fail_cnt++;
            $error("start held for more than one cycle");
        end

    a_finished_pulse: assert property (@(posedge avm_clk) disable iff (avm_rst)
        $past(finished) |-> !finished)
        else begin
            fail_cnt++;
            $error("finished held for more than one cycle");
        end

    a_idle_after_reset: assert property (@(posedge avm_clk)
        ($past(avm_rst) && !avm_rst) |-> !(cmd.read || cmd.write))
        else begin
            fail_cnt++;
            $error("bus strobe active in the first cycle after reset");
        end

endmodule

bind rsa_wrapper rsa_chk i_chk (
    .avm_clk         (avm_clk),
    .avm_rst         (avm_rst),
    .cmd             (cmd),
    .avm_waitrequest (avm_waitrequest),
    .start           (start),
    .finished        (finished)
);

// ==== bench/rsa_tb.sv ====
`timescale 1ns/1ps
`include "rsa_config.svh"

module rsa_tb;

    localparam int num_frames       = 6;
    localparam int cycles_per_frame = 3 * 258 * 258 + 2000;

    logic        avm_clk;
    logic        avm_rst = 1'b1;
    logic [4:0]  avm_address;
    logic        avm_read;
    logic [31:0] avm_readdata = 32'd0;
    logic        avm_write;
    logic [31:0] avm_writedata;
    logic        avm_waitrequest = 1'b1;

    // serial peripheral model.
    logic [7:0]           rx_q[$];
    logic [7:0]           tx_q[$];
    logic [`RSA_BITS-1:0] core_q[$];
    logic                 tx_ready = 1'b1;
    int                   tx_stall_len = 0;
    int                   tx_stall_cnt = 0;
    int                   rst_cnt = 0;
    logic [31:0]          bus_seed = 32'h62f9;
    logic [31:0]          op_seed = 32'h62f9;
    int                   model_errors = 0;
    int                   check_errors = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;

    rsa_wrapper i_dut (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest)
    );

    initial begin
        avm_clk = 1'b0;
        forever #5 avm_clk = ~avm_clk;
    end

    // reset spans the first 16 rising edges.
    always @(posedge avm_clk) begin
        if (rst_cnt < 15) begin
            rst_cnt <= rst_cnt + 1;
        end else begin
            avm_rst <= 1'b0;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [`RSA_BITS-1:0] draw_wide();
        logic [`RSA_BITS-1:0] v;
        int                   i;
        v = '0;
        for (i = 0; i < `RSA_BITS / 32; i++) begin
            op_seed = lcg_next(op_seed);
            v       = {v[`RSA_BITS-33:0], op_seed};
        end
        return v;
    endfunction

    // plain square-and-multiply on double-width values.
    function automatic logic [`RSA_BITS-1:0] mod_exp(input rsa_pkg::operands_t op);
        logic [2*`RSA_BITS-1:0] r;
        logic [2*`RSA_BITS-1:0] b;
        logic [2*`RSA_BITS-1:0] m;
        int                     i;
        m = {{`RSA_BITS{1'b0}}, op.n};
        r = 1;
        b = {{`RSA_BITS{1'b0}}, op.a} % m;
        for (i = 0; i < `RSA_BITS; i++) begin
            if (op.d[i]) begin
                r = (r * b) % m;
            end
            b = (b * b) % m;
        end
        return r[`RSA_BITS-1:0];
    endfunction

    function automatic int total_errors();
        return check_errors + model_errors + i_dut.i_chk.fail_cnt;
    endfunction

    task automatic serve_access();
        logic [31:0] status;
        status                 = 32'd0;
        status[`AVM_RX_OK_BIT] = (rx_q.size() != 0);
        status[`AVM_TX_OK_BIT] = tx_ready;
        if (avm_read && avm_address == `AVM_STATUS_ADDR) begin
            avm_readdata <= status;
        end else if (avm_read && avm_address == `AVM_RX_ADDR) begin
            if (rx_q.size() == 0) begin
                $display("RX register read while the receive queue was empty");
                model_errors++;
            end else begin
                avm_readdata <= {24'd0, rx_q.pop_front()};
            end
        end else if (avm_write && avm_address == `AVM_TX_ADDR) begin
            if (!tx_ready) begin
                $display("TX register written while the transmitter was not ready");
                model_errors++;
            end else begin
                tx_q.push_back(avm_writedata[7:0]);
                // stall after the first byte of a result.
                if (tx_stall_len != 0 && tx_q.size() == 1) begin
                    tx_ready     <= 1'b0;
                    tx_stall_cnt <= tx_stall_len;
                end
            end
        end else begin
            $display("bus access to unmapped address 0x%02h", avm_address);
            model_errors++;
        end
    endtask

    always @(posedge avm_clk) begin
        bus_seed = lcg_next(bus_seed);
        if (avm_rst) begin
            avm_waitrequest <= 1'b1;
        end else if (!avm_waitrequest) begin
            avm_waitrequest <= 1'b1;
        end else if ((avm_read || avm_write) && bus_seed[31:30] != 2'b00) begin
            avm_waitrequest <= 1'b0;
            serve_access();
        end
        if (tx_stall_cnt == 1) begin
            tx_ready <= 1'b1;
        end
        if (tx_stall_cnt != 0) begin
            tx_stall_cnt <= tx_stall_cnt - 1;
        end
        if (!avm_rst && i_dut.finished) begin
            core_q.push_back(i_dut.result);
        end
    end

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] want);
        if (got !== want) begin
            $display("Error %s: got 0x%02h, expected 0x%02h", name, got, want);
            check_errors++;
        end
    endtask

    task automatic check_result(input string name, input logic [`RSA_BITS-1:0] got,
                                input logic [`RSA_BITS-1:0] want);
        if (got !== want) begin
            $display("Error %s: got 0x%064h, expected 0x%064h", name, got, want);
            check_errors++;
        end
    endtask

    // n, then d, then a, each msb first.
    task automatic push_frame(input rsa_pkg::operands_t op, input int gap);
        int i;
        for (i = 0; i < 3 * `RSA_IN_BYTES; i++) begin
            repeat (gap) @(negedge avm_clk);
            rx_q.push_back(op[3*`RSA_BITS-1 - 8*i -: 8]);
        end
    endtask

    task automatic collect_frame(input rsa_pkg::operands_t op);
        logic [`RSA_BITS-1:0] want;
        int                   i;
        want = mod_exp(op);
        while (tx_q.size() < `RSA_OUT_BYTES) begin
            @(negedge avm_clk);
        end
        for (i = 0; i < `RSA_OUT_BYTES; i++) begin
            check_byte($sformatf("avm_writedata[%0d]", i), tx_q.pop_front(),
                       want[8*(`RSA_OUT_BYTES-1-i) +: 8]);
        end
        if (core_q.size() == 0) begin
            $display("frame was sent but the core never signalled a result");
            check_errors++;
        end else begin
            check_result("result", core_q.pop_front(), want);
        end
    endtask

    function automatic rsa_pkg::operands_t random_operands();
        rsa_pkg::operands_t op;
        op.n = draw_wide() | {1'b1, {(`RSA_BITS-2){1'b0}}, 1'b1};
        op.d = draw_wide();
        op.a = draw_wide() % op.n;
        return op;
    endfunction

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (total_errors() != errs_before) begin
            tests_failed++;
            $display("%s: failed", name);
        end else begin
            $display("%s: passed", name);
        end
    endtask

    task automatic run_single(input string name, input rsa_pkg::operands_t op, input int gap);
        int e0;
        e0 = total_errors();
        push_frame(op, gap);
        collect_frame(op);
        finish_test(name, e0);
    endtask

    task automatic test_back_to_back();
        rsa_pkg::operands_t op1;
        rsa_pkg::operands_t op2;
        int                 e0;
        e0  = total_errors();
        op1 = random_operands();
        op2 = random_operands();
        push_frame(op1, 0);
        push_frame(op2, 0);
        collect_frame(op1);
        collect_frame(op2);
        finish_test("back-to-back frames", e0);
    endtask

    initial begin
        wait (!avm_rst);
        @(negedge avm_clk);
        run_single("small operands", {`RSA_BITS'h0bb, `RSA_BITS'h17, `RSA_BITS'h2a}, 0);
        run_single("random operands", random_operands(), 0);
        run_single("rx starvation", random_operands(), 25);
        tx_stall_len = 400;
        run_single("tx back-pressure", random_operands(), 0);
        tx_stall_len = 0;
        test_back_to_back();
        if (tx_q.size() != 0 || core_q.size() != 0) begin
            $display("unexpected extra data after the last frame");
            check_errors++;
        end
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        repeat (num_frames * cycles_per_frame) @(posedge avm_clk);
        $display("watchdog expired before all tests finished");
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+common
common/rsa_pkg.sv
source/avm_master.sv
source/frame_loader.sv
source/frame_sender.sv
rsa_core/mont_mult.sv
rsa_core/rsa_core.sv
source/rsa_wrapper.sv
bench/rsa_chk.sv
bench/rsa_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the rsa testbench with verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -f src.f --top-module rsa_tb \
    -Mdir "$build_dir" -o rsa_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./"$build_dir"/rsa_tb_sim +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test OK$" "$log"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
